//--- Makefile
# Verilator build and run for the SAT engine testbench

VERILATOR ?= verilator
TOP       ?= tb_sat_engine
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(wildcard hdl/*.sv tb/*.sv) $(FILELIST)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "simulation reported failure" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hdl/sat_pkg.sv
hdl/sat_if.sv
hdl/ctrl_core.sv
hdl/state_list.sv
hdl/clause_array.sv
hdl/sat_engine.sv
tb/sat_checker.sv
tb/sat_engine_assert.sv
tb/tb_sat_engine.sv

//--- hdl/clause_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clause store with host access and clause evaluation
// bit 2v is literal v, bit 2v+1 is literal not v
// an all-zero clause is unused and never fires
// write only while the engine is idle or done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module clause_array #(
    parameter int NUM_VARS    = sat_pkg::DEF_NUM_VARS,
    parameter int NUM_CLAUSES = sat_pkg::DEF_NUM_CLAUSES
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [NUM_CLAUSES-1:0]  wr_carray_i,
    input  logic [NUM_CLAUSES-1:0]  rd_carray_i,
    input  logic [2*NUM_VARS-1:0]   clause_i,
    output logic [2*NUM_VARS-1:0]   clause_o,
    sat_if.carray                   sif
);

    logic [2*NUM_VARS-1:0] clause_q [NUM_CLAUSES];
    logic [2*NUM_VARS-1:0] rd_mux;
    logic [NUM_VARS-1:0]   free_vec [NUM_CLAUSES];
    logic [NUM_VARS-1:0]   pos_vec  [NUM_CLAUSES];
    logic [NUM_VARS-1:0]   true_vec [NUM_CLAUSES];
    logic [NUM_CLAUSES-1:0] unit_c;
    logic [NUM_CLAUSES-1:0] confl_c;

    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            if (rst_i) clause_q[c] <= '0;
            else if (wr_carray_i[c]) clause_q[c] <= clause_i;
        end
    end

    always_comb begin
        rd_mux = '0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            if (rd_carray_i[c]) rd_mux = rd_mux | clause_q[c];
        end
    end

    always_ff @(posedge clk) begin
        clause_o <= rd_mux;
    end

    always_comb begin
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                pos_vec[c][v]  = clause_q[c][2*v];
                free_vec[c][v] = (clause_q[c][2*v] || clause_q[c][2*v+1]) &&
                                 (sif.var_val[v] == sat_pkg::VAL_FREE);
                true_vec[c][v] = (clause_q[c][2*v] && sif.var_val[v] == sat_pkg::VAL_TRUE) ||
                                 (clause_q[c][2*v+1] && sif.var_val[v] == sat_pkg::VAL_FALSE);
            end
            // unit means exactly one free variable left
            unit_c[c]  = (clause_q[c] != '0) && (true_vec[c] == '0) && (free_vec[c] != '0) &&
                         ((free_vec[c] & (free_vec[c] - 1'b1)) == '0);
            confl_c[c] = (clause_q[c] != '0) && (true_vec[c] == '0) && (free_vec[c] == '0);
        end
    end

    always_comb begin
        sif.imply_valid = 1'b0;
        sif.imply_var   = '0;
        sif.imply_val   = sat_pkg::VAL_FREE;
        // scan downwards so the lowest unit clause wins
        for (int c = NUM_CLAUSES - 1; c >= 0; c--) begin
            if (unit_c[c]) begin
                sif.imply_valid = 1'b1;
                sif.imply_var   = free_vec[c];
                sif.imply_val   = |(free_vec[c] & pos_vec[c]) ? sat_pkg::VAL_TRUE
                                                              : sat_pkg::VAL_FALSE;
            end
        end
        sif.conflict = |confl_c;
    end

endmodule

`default_nettype wire

//--- hdl/ctrl_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DPLL sequencer: imply, decide, backtrack
// start_i is only sampled in CORE_IDLE
// sat_o and unsat_o hold until the next accepted start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ctrl_core (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    output logic done_o,
    output logic sat_o,
    output logic unsat_o,
    output logic apply_imply_o,
    output logic start_decision_o,
    input  logic done_decision_i,
    output logic apply_bkt_o,
    input  logic done_bkt_i,
    input  logic bkt_fail_i,
    output logic clear_assign_o,
    sat_if.ctrl  sif
);

    sat_pkg::core_state_e state_q;
    sat_pkg::core_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sat_pkg::CORE_IDLE: begin
                if (start_i) state_d = sat_pkg::CORE_IMPLY;
            end
            sat_pkg::CORE_IMPLY: begin
                if (sif.conflict) begin
                    state_d = sat_pkg::CORE_BKT;
                end else if (!sif.imply_valid) begin
                    state_d = sif.all_assigned ? sat_pkg::CORE_DONE : sat_pkg::CORE_DECIDE;
                end
            end
            sat_pkg::CORE_DECIDE: begin
                if (done_decision_i) state_d = sat_pkg::CORE_IMPLY;
            end
            sat_pkg::CORE_BKT: begin
                if (done_bkt_i) begin
                    state_d = bkt_fail_i ? sat_pkg::CORE_DONE : sat_pkg::CORE_IMPLY;
                end
            end
            default: state_d = sat_pkg::CORE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q          <= sat_pkg::CORE_IDLE;
            start_decision_o <= 1'b0;
            sat_o            <= 1'b0;
            unsat_o          <= 1'b0;
        end else begin
            state_q <= state_d;
            // one pulse on entry to DECIDE
            start_decision_o <= (state_q == sat_pkg::CORE_IMPLY) &&
                                (state_d == sat_pkg::CORE_DECIDE);
            if (clear_assign_o) begin
                sat_o   <= 1'b0;
                unsat_o <= 1'b0;
            end
            if (state_q == sat_pkg::CORE_IMPLY && state_d == sat_pkg::CORE_DONE) sat_o <= 1'b1;
            if (state_q == sat_pkg::CORE_BKT && state_d == sat_pkg::CORE_DONE) unsat_o <= 1'b1;
        end
    end

    assign apply_imply_o  = (state_q == sat_pkg::CORE_IMPLY);
    assign apply_bkt_o    = (state_q == sat_pkg::CORE_BKT);
    assign done_o         = (state_q == sat_pkg::CORE_DONE);
    assign clear_assign_o = (state_q == sat_pkg::CORE_IDLE) && start_i;

endmodule

`default_nettype wire

//--- hdl/sat_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DPLL SAT engine for one bin of clauses
// model_o is valid only after done_o with sat_o
// start_i is ignored while a search runs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module sat_engine #(
    parameter int NUM_VARS    = sat_pkg::DEF_NUM_VARS,
    parameter int NUM_CLAUSES = sat_pkg::DEF_NUM_CLAUSES
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  logic [NUM_CLAUSES-1:0]        wr_carray_i,
    input  logic [NUM_CLAUSES-1:0]        rd_carray_i,
    input  logic [2*NUM_VARS-1:0]         clause_i,
    output logic [2*NUM_VARS-1:0]         clause_o,
    output logic                          done_o,
    output logic                          sat_o,
    output logic                          unsat_o,
    output logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_o,
    output logic [NUM_VARS-1:0]           model_o
);

    logic apply_imply;
    logic start_decision;
    logic done_decision;
    logic apply_bkt;
    logic done_bkt;
    logic bkt_fail;
    logic clear_assign;

    sat_if #(.NUM_VARS(NUM_VARS)) sat_bus ();

    ctrl_core ctrl_core_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .done_o          (done_o),
        .sat_o           (sat_o),
        .unsat_o         (unsat_o),
        .apply_imply_o   (apply_imply),
        .start_decision_o(start_decision),
        .done_decision_i (done_decision),
        .apply_bkt_o     (apply_bkt),
        .done_bkt_i      (done_bkt),
        .bkt_fail_i      (bkt_fail),
        .clear_assign_o  (clear_assign),
        .sif             (sat_bus.ctrl)
    );

    state_list #(.NUM_VARS(NUM_VARS)) state_list_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .clear_assign_i  (clear_assign),
        .apply_imply_i   (apply_imply),
        .start_decision_i(start_decision),
        .done_decision_o (done_decision),
        .apply_bkt_i     (apply_bkt),
        .done_bkt_o      (done_bkt),
        .bkt_fail_o      (bkt_fail),
        .cur_lvl_o       (cur_lvl_o),
        .model_o         (model_o),
        .sif             (sat_bus.stlist)
    );

    clause_array #(
        .NUM_VARS   (NUM_VARS),
        .NUM_CLAUSES(NUM_CLAUSES)
    ) clause_array_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_carray_i(wr_carray_i),
        .rd_carray_i(rd_carray_i),
        .clause_i   (clause_i),
        .clause_o   (clause_o),
        .sif        (sat_bus.carray)
    );

endmodule

`default_nettype wire

//--- hdl/sat_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// links clause array, state list and controller
// imply_var is one-hot over the variables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface sat_if #(
    parameter int NUM_VARS = sat_pkg::DEF_NUM_VARS
);

    sat_pkg::var_val_e   var_val [NUM_VARS];
    logic                imply_valid;
    logic [NUM_VARS-1:0] imply_var;
    sat_pkg::var_val_e   imply_val;
    logic                conflict;
    logic                all_assigned;

    modport carray (
        input  var_val,
        output imply_valid, imply_var, imply_val, conflict
    );

    modport stlist (
        input  imply_valid, imply_var, imply_val, conflict,
        output var_val, all_assigned
    );

    modport ctrl (
        input imply_valid, conflict, all_assigned
    );

endinterface

`default_nettype wire

//--- hdl/sat_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and default sizes for the SAT engine
// WIDTH_LVL must be able to count up to NUM_VARS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sat_pkg;

    localparam int DEF_NUM_VARS    = 8;
    localparam int DEF_NUM_CLAUSES = 8;
    localparam int WIDTH_LVL       = 4;

    typedef enum logic [1:0] {
        VAL_FREE  = 2'd0,
        VAL_TRUE  = 2'd1,
        VAL_FALSE = 2'd2
    } var_val_e;

    // search controller states
    typedef enum logic [2:0] {
        CORE_IDLE   = 3'd0,
        CORE_IMPLY  = 3'd1,
        CORE_DECIDE = 3'd2,
        CORE_BKT    = 3'd3,
        CORE_DONE   = 3'd4
    } core_state_e;

endpackage

`default_nettype wire

//--- hdl/state_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-variable value, level and decision flags
// decisions pick the lowest free variable, set true
// backtrack unwinds one level per cycle
// imply is ignored while a conflict is present
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module state_list #(
    parameter int NUM_VARS = sat_pkg::DEF_NUM_VARS
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          clear_assign_i,
    input  logic                          apply_imply_i,
    input  logic                          start_decision_i,
    output logic                          done_decision_o,
    input  logic                          apply_bkt_i,
    output logic                          done_bkt_o,
    output logic                          bkt_fail_o,
    output logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_o,
    output logic [NUM_VARS-1:0]           model_o,
    sat_if.stlist                         sif
);

    sat_pkg::var_val_e             val_q [NUM_VARS];
    logic [sat_pkg::WIDTH_LVL-1:0] lvl_q [NUM_VARS];
    logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_q;
    logic [NUM_VARS-1:0]           is_dec_q;
    logic [NUM_VARS-1:0]           flip_q;
    logic [NUM_VARS-1:0]           free_mask;
    logic [NUM_VARS-1:0]           lvl_hit;
    logic [NUM_VARS-1:0]           dec_sel;
    logic                          dec_flipped;
    logic                          do_imply;

    always_comb begin
        for (int v = 0; v < NUM_VARS; v++) begin
            free_mask[v] = (val_q[v] == sat_pkg::VAL_FREE);
            lvl_hit[v]   = (lvl_q[v] == cur_lvl_q);
            model_o[v]   = (val_q[v] == sat_pkg::VAL_TRUE);
        end
    end

    // isolate lowest free variable
    assign dec_sel     = free_mask & (~free_mask + 1'b1);
    assign dec_flipped = |(lvl_hit & is_dec_q & flip_q);
    assign do_imply    = apply_imply_i && sif.imply_valid && !sif.conflict;

    assign sif.var_val      = val_q;
    assign sif.all_assigned = (free_mask == '0);
    assign cur_lvl_o        = cur_lvl_q;

    // level 0 holds no decision, nothing left to flip
    assign bkt_fail_o = apply_bkt_i && (cur_lvl_q == '0);
    assign done_bkt_o = apply_bkt_i && ((cur_lvl_q == '0) || !dec_flipped);

    always_ff @(posedge clk) begin
        if (rst_i || clear_assign_i) begin
            cur_lvl_q       <= '0;
            done_decision_o <= 1'b0;
            is_dec_q        <= '0;
            flip_q          <= '0;
            for (int v = 0; v < NUM_VARS; v++) begin
                val_q[v] <= sat_pkg::VAL_FREE;
                lvl_q[v] <= '0;
            end
        end else begin
            done_decision_o <= start_decision_i;
            if (start_decision_i) begin
                cur_lvl_q <= cur_lvl_q + 1'b1;
                for (int v = 0; v < NUM_VARS; v++) begin
                    if (dec_sel[v]) begin
                        val_q[v]    <= sat_pkg::VAL_TRUE;
                        lvl_q[v]    <= cur_lvl_q + 1'b1;
                        is_dec_q[v] <= 1'b1;
                        flip_q[v]   <= 1'b0;
                    end
                end
            end else if (apply_bkt_i && cur_lvl_q != '0) begin
                // both branches tried, drop the whole level
                if (dec_flipped) cur_lvl_q <= cur_lvl_q - 1'b1;
                for (int v = 0; v < NUM_VARS; v++) begin
                    if (lvl_hit[v]) begin
                        if (is_dec_q[v] && !dec_flipped) begin
                            val_q[v]  <= sat_pkg::VAL_FALSE;
                            flip_q[v] <= 1'b1;
                        end else begin
                            val_q[v]    <= sat_pkg::VAL_FREE;
                            is_dec_q[v] <= 1'b0;
                            flip_q[v]   <= 1'b0;
                        end
                    end
                end
            end else if (do_imply) begin
                for (int v = 0; v < NUM_VARS; v++) begin
                    if (sif.imply_var[v]) begin
                        val_q[v]    <= sif.imply_val;
                        lvl_q[v]    <= cur_lvl_q;
                        is_dec_q[v] <= 1'b0;
                        flip_q[v]   <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/sat_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches the DUT ports and keeps a copy of the clauses
// verdicts are checked by enumerating all assignments
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module sat_checker #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [NUM_CLAUSES-1:0]        wr_carray_i,
    input  logic [NUM_CLAUSES-1:0]        rd_carray_i,
    input  logic [2*NUM_VARS-1:0]         clause_i,
    input  logic [2*NUM_VARS-1:0]         clause_o,
    input  logic                          done_o,
    input  logic                          sat_o,
    input  logic                          unsat_o,
    input  logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_o,
    input  logic [NUM_VARS-1:0]           model_o,
    output int                            err_cnt_o,
    output int                            done_cnt_o
);

    logic [2*NUM_VARS-1:0] shadow [NUM_CLAUSES];
    logic [2*NUM_VARS-1:0] rd_exp;
    logic                  rd_pend;
    bit                    exp_sat;

    // empty clause counts as satisfied
    function automatic bit clause_holds(input logic [2*NUM_VARS-1:0] cl,
                                        input logic [NUM_VARS-1:0] asg);
        bit hit;
        hit = (cl == '0);
        for (int v = 0; v < NUM_VARS; v++) begin
            if ((cl[2*v] && asg[v]) || (cl[2*v+1] && !asg[v])) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic bit all_hold(input logic [NUM_VARS-1:0] asg);
        bit ok;
        ok = 1'b1;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            if (!clause_holds(shadow[c], asg)) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic bit brute_force_sat();
        bit found;
        found = 1'b0;
        for (int a = 0; a < (1 << NUM_VARS); a++) begin
            if (all_hold(a[NUM_VARS-1:0])) found = 1'b1;
        end
        return found;
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            for (int c = 0; c < NUM_CLAUSES; c++) shadow[c] = '0;
            rd_pend    = 1'b0;
            err_cnt_o  = 0;
            done_cnt_o = 0;
        end else begin
            if (rd_pend && clause_o !== rd_exp) begin
                $display("FAIL %0t: readback %h, expected %h", $time, clause_o, rd_exp);
                err_cnt_o++;
            end
            // one decision per level at most
            if (cur_lvl_o > NUM_VARS) begin
                $display("FAIL %0t: level %0d above %0d", $time, cur_lvl_o, NUM_VARS);
                err_cnt_o++;
            end
            // read sees the array before this edge's write
            rd_pend = (rd_carray_i != '0);
            rd_exp  = '0;
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                if (rd_carray_i[c]) rd_exp = rd_exp | shadow[c];
            end
            for (int c = 0; c < NUM_CLAUSES; c++) begin
                if (wr_carray_i[c]) shadow[c] = clause_i;
            end
            if (done_o) begin
                done_cnt_o++;
                exp_sat = brute_force_sat();
                if (sat_o !== exp_sat || unsat_o !== !exp_sat) begin
                    $display("FAIL %0t: verdict sat=%b unsat=%b, expected sat=%b",
                             $time, sat_o, unsat_o, exp_sat);
                    err_cnt_o++;
                end
                if (sat_o === 1'b1 && !all_hold(model_o)) begin
                    $display("FAIL %0t: model %b violates a clause", $time, model_o);
                    err_cnt_o++;
                end
                // unsat only after unwinding to level 0
                if (unsat_o === 1'b1 && cur_lvl_o !== '0) begin
                    $display("FAIL %0t: level %0d at unsat, expected 0", $time, cur_lvl_o);
                    err_cnt_o++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/sat_engine_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol assertions, bound into sat_engine
// fail_cnt is read by the testbench at the end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module sat_engine_assert #(
    parameter int NUM_VARS = sat_pkg::DEF_NUM_VARS
) (
    input logic                          clk,
    input logic                          rst_i,
    input logic                          done_i,
    input logic                          sat_i,
    input logic                          unsat_i,
    input logic                          apply_imply_i,
    input logic                          conflict_i,
    input logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_i,
    input logic [NUM_VARS-1:0]           model_i,
    input sat_pkg::core_state_e          state_i
);

    int fail_cnt = 0;

    done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_i |=> !done_i)
        else begin $error("done_o held longer than one cycle"); fail_cnt++; end

    verdict_excl: assert property (@(posedge clk) disable iff (rst_i) !(sat_i && unsat_i))
        else begin $error("sat_o and unsat_o high together"); fail_cnt++; end

    verdict_on_done: assert property (@(posedge clk) disable iff (rst_i)
        done_i |-> (sat_i || unsat_i))
        else begin $error("done_o without a verdict"); fail_cnt++; end

    // a conflict must block the implication and lead to backtrack
    no_imply_on_conflict: assert property (@(posedge clk) disable iff (rst_i)
        apply_imply_i && conflict_i |=>
        state_i == sat_pkg::CORE_BKT && $stable(model_i) && $stable(cur_lvl_i))
        else begin $error("implication applied during a conflict"); fail_cnt++; end

endmodule

bind sat_engine sat_engine_assert #(.NUM_VARS(NUM_VARS)) sat_engine_assert_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .done_i       (done_o),
    .sat_i        (sat_o),
    .unsat_i      (unsat_o),
    .apply_imply_i(apply_imply),
    .conflict_i   (sat_bus.conflict),
    .cur_lvl_i    (cur_lvl_o),
    .model_i      (model_o),
    .state_i      (ctrl_core_i.state_q)
);

`default_nettype wire

//--- tb/tb_sat_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for sat_engine
// random problems of 1 to 3 literals per clause
// inputs change 2 ns after the rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_sat_engine;

    localparam int NUM_VARS    = sat_pkg::DEF_NUM_VARS;
    localparam int NUM_CLAUSES = sat_pkg::DEF_NUM_CLAUSES;
    localparam int TIMEOUT     = 20000;

    logic                          clk;
    logic                          rst_i;
    logic                          start_i;
    logic [NUM_CLAUSES-1:0]        wr_carray_i;
    logic [NUM_CLAUSES-1:0]        rd_carray_i;
    logic [2*NUM_VARS-1:0]         clause_i;
    logic [2*NUM_VARS-1:0]         clause_o;
    logic                          done_o;
    logic                          sat_o;
    logic                          unsat_o;
    logic [sat_pkg::WIDTH_LVL-1:0] cur_lvl_o;
    logic [NUM_VARS-1:0]           model_o;
    logic [2*NUM_VARS-1:0]         prob [NUM_CLAUSES];
    logic [31:0]                   lcg_state;
    int                            chk_errs;
    int                            done_cnt;
    int                            tb_errs;
    int                            total;
    bit                            last_sat;
    bit                            first_sat;

    sat_engine #(.NUM_VARS(NUM_VARS), .NUM_CLAUSES(NUM_CLAUSES)) sat_engine_i (.*);

    sat_checker #(.NUM_VARS(NUM_VARS), .NUM_CLAUSES(NUM_CLAUSES)) checker_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_carray_i(wr_carray_i),
        .rd_carray_i(rd_carray_i),
        .clause_i   (clause_i),
        .clause_o   (clause_o),
        .done_o     (done_o),
        .sat_o      (sat_o),
        .unsat_o    (unsat_o),
        .cur_lvl_o  (cur_lvl_o),
        .model_o    (model_o),
        .err_cnt_o  (chk_errs),
        .done_cnt_o (done_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic read_clause(input int idx);
        @(posedge clk);
        #2 rd_carray_i = NUM_CLAUSES'(1) << idx;
        @(posedge clk);
        #2 rd_carray_i = '0;
    endtask

    // write then read back the same slot
    task automatic write_clause(input int idx, input logic [2*NUM_VARS-1:0] cl);
        @(posedge clk);
        #2;
        wr_carray_i = NUM_CLAUSES'(1) << idx;
        clause_i    = cl;
        @(posedge clk);
        #2 wr_carray_i = '0;
        rd_carray_i = NUM_CLAUSES'(1) << idx;
        @(posedge clk);
        #2 rd_carray_i = '0;
    endtask

    task automatic load_problem();
        for (int c = 0; c < NUM_CLAUSES; c++) write_clause(c, prob[c]);
    endtask

    task automatic make_random_problem();
        int nlit;
        int v;
        int bit_pos;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            prob[c] = '0;
            nlit = 1 + int'((lcg_next() >> 16) % 3);
            for (int k = 0; k < nlit; k++) begin
                v       = int'((lcg_next() >> 16) % NUM_VARS);
                bit_pos = 2 * v + int'(lcg_next() >> 31);
                prob[c][bit_pos] = 1'b1;
            end
        end
    endtask

    // busy_start repeats start_i while the search is running
    task automatic run_solver(input bit busy_start);
        int prev;
        int n;
        prev = done_cnt;
        n    = 0;
        @(posedge clk);
        #2 start_i = 1'b1;
        @(posedge clk);
        #2 start_i = busy_start;
        @(posedge clk);
        #2 start_i = 1'b0;
        while (!done_o && n < TIMEOUT) begin
            @(posedge clk);
            #2 n++;
        end
        if (n >= TIMEOUT) begin
            $display("timeout: done_o never came after start_i at %0t", $time);
            tb_errs++;
        end else begin
            last_sat = sat_o;
            repeat (4) @(posedge clk);
            #2;
            if (done_cnt != prev + 1) begin
                $display("FAIL %0t: %0d done pulses for one run", $time, done_cnt - prev);
                tb_errs++;
            end
            // verdict holds until a start is accepted
            if (sat_o !== last_sat || unsat_o !== !last_sat) begin
                $display("FAIL %0t: verdict sat=%b unsat=%b not held after done_o",
                         $time, sat_o, unsat_o);
                tb_errs++;
            end
        end
    endtask

    initial begin
        rst_i       = 1'b1;
        start_i     = 1'b0;
        wr_carray_i = '0;
        rd_carray_i = '0;
        clause_i    = '0;
        lcg_state   = 32'h1f8f_0197;
        tb_errs     = 0;
        last_sat    = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst_i = 1'b0;

        if (done_o !== 1'b0 || sat_o !== 1'b0 || unsat_o !== 1'b0 ||
            cur_lvl_o !== '0 || model_o !== '0) begin
            $display("FAIL %0t: outputs not cleared by reset", $time);
            tb_errs++;
        end

        for (int c = 0; c < NUM_CLAUSES; c++) read_clause(c);

        // (x0) and (not x0)
        for (int c = 0; c < NUM_CLAUSES; c++) prob[c] = '0;
        prob[0] = 2'b01;
        prob[1] = 2'b10;
        load_problem();
        run_solver(1'b0);
        if (last_sat !== 1'b0 || unsat_o !== 1'b1) begin
            $display("FAIL %0t: contradiction not reported unsat", $time);
            tb_errs++;
        end

        // no clauses, so every variable is a decision set true
        for (int c = 0; c < NUM_CLAUSES; c++) prob[c] = '0;
        load_problem();
        run_solver(1'b0);
        if (last_sat !== 1'b1) begin
            $display("FAIL %0t: empty problem not reported sat", $time);
            tb_errs++;
        end
        if (cur_lvl_o !== NUM_VARS || model_o !== '1) begin
            $display("FAIL %0t: empty problem level %0d model %b, expected %0d and all ones",
                     $time, cur_lvl_o, model_o, NUM_VARS);
            tb_errs++;
        end

        for (int p = 0; p < 40; p++) begin
            make_random_problem();
            load_problem();
            run_solver(1'b0);
            first_sat = last_sat;
            run_solver(1'b1);
            if (last_sat !== first_sat) begin
                $display("FAIL %0t: restart of problem %0d changed the verdict", $time, p);
                tb_errs++;
            end
        end

        total = tb_errs + chk_errs + sat_engine_i.sat_engine_assert_i.fail_cnt;
        $display("errors: %0d (driver %0d, checker %0d, assertions %0d)", total, tb_errs,
                 chk_errs, sat_engine_i.sat_engine_assert_i.fail_cnt);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
